/* hdl/av_settings.svh */
/*
 * shared constants for the audio/video pattern core
 * raster geometry, test pattern colours and i2s framing
 */
`ifndef AV_SETTINGS_SVH
`define AV_SETTINGS_SVH

////////////////////
// raster geometry
////////////////////

// counter extents
`define AV_H_TOTAL          400
`define AV_V_TOTAL          512

// active window offset from counter origin
`define AV_H_BPORCH         10
`define AV_V_BPORCH         10

// active window size
`define AV_H_ACTIVE         320
`define AV_V_ACTIVE         240

// hsync column, kept clear of the vsync cycle
`define AV_HS_COLUMN        3

////////////////////
// test pattern
////////////////////

// red band limits in raw counter units
`define AV_RED_COLUMN_END   60
`define AV_RED_LINE_START   200

// per-channel level of the grey area
`define AV_GREY_LEVEL       60

////////////////////
// i2s framing
////////////////////

`define AV_MCLK_PER_BIT     4
`define AV_SLOT_BITS        32
`define AV_SAMPLE_BITS      16

`endif

/* hdl/video_pkg.sv */
/*
 * video types
 * raster positions and pixel colour
 */
package video_pkg;

    ////////////////////
    // raster
    ////////////////////

    // column or line position
    // 10 bits covers the 512-line frame
    typedef logic [9:0] raster_pos_t;

    ////////////////////
    // colour
    ////////////////////

    // 8 bits per channel
    // red [23:16], green [15:8], blue [7:0]
    typedef logic [23:0] pixel_rgb_t;

endpackage

/* hdl/audio_pkg.sv */
/*
 * audio types
 * samples, slot bit positions and the sample handshake FSM
 */
`include "av_settings.svh"

package audio_pkg;

    // one channel sample, two's complement
    typedef logic [`AV_SAMPLE_BITS-1:0] audio_sample_t;

    // bit position inside one channel slot
    typedef logic [$clog2(`AV_SLOT_BITS)-1:0] slot_bit_t;

    ////////////////////
    // sample handshake
    ////////////////////

    // IDLE     buffer full or waiting for ack low
    // REQUEST  req high, waiting for ack
    // RELEASE  pair taken, waiting for ack to drop
    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        RELEASE
    } handshake_state_t;

endpackage

/* hdl/video_timing.sv */
/*
 * video timing
 * column and line counters over the full raster
 * plus one-cycle vertical and horizontal sync pulses
 */
`include "av_settings.svh"

module video_timing (
    input  logic                   audgen_mclk,
    input  logic                   reset_n,
    output video_pkg::raster_pos_t x_pos,
    output video_pkg::raster_pos_t y_pos,
    output logic                   hs,
    output logic                   vs
);
    import video_pkg::*;

    // last column and line before wrap
    localparam raster_pos_t H_LAST = raster_pos_t'(`AV_H_TOTAL - 1);
    localparam raster_pos_t V_LAST = raster_pos_t'(`AV_V_TOTAL - 1);
    localparam raster_pos_t HS_COL = raster_pos_t'(`AV_HS_COLUMN);

    logic line_end;

    assign line_end = (x_pos == H_LAST);

    ////////////////////
    // counters
    ////////////////////

    // column steps every clock
    // line steps on column wrap
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            x_pos <= '0;
            y_pos <= '0;
        end else if (line_end) begin
            x_pos <= '0;
            if (y_pos == V_LAST) begin
                y_pos <= '0;
            end else begin
                y_pos <= y_pos + 1'b1;
            end
        end else begin
            x_pos <= x_pos + 1'b1;
        end
    end

    ////////////////////
    // syncs
    ////////////////////

    // registered, so both pulses trail their position by one clock
    // same delay as the pattern path
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            vs <= 1'b0;
            hs <= 1'b0;
        end else begin
            // new frame at counter origin
            vs <= (x_pos == '0) && (y_pos == '0);
            // new line a few clocks later
            hs <= (x_pos == HS_COL);
        end
    end

    // scaler needs the two syncs apart
    a_sync_apart: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        !(hs && vs));

    // every frame opens with its first line sync
    a_vs_then_hs: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        vs |-> ##(`AV_HS_COLUMN) hs);

endmodule

/* hdl/test_pattern.sv */
/*
 * test pattern
 * grey window with red bands, black outside the active area
 * de and colour registered from the raster position
 */
`include "av_settings.svh"

module test_pattern (
    input  logic                   audgen_mclk,
    input  logic                   reset_n,
    input  video_pkg::raster_pos_t x_pos,
    input  video_pkg::raster_pos_t y_pos,
    output logic                   de,
    output video_pkg::pixel_rgb_t  rgb
);
    import video_pkg::*;

    localparam pixel_rgb_t RED   = 24'hff0000;
    localparam pixel_rgb_t GREY  = {3{8'(`AV_GREY_LEVEL)}};
    localparam pixel_rgb_t BLACK = '0;

    logic       in_window;
    logic       in_red;
    pixel_rgb_t rgb_next;

    // active window, offset from the counter origin
    assign in_window = (x_pos >= `AV_H_BPORCH) &&
                       (x_pos < `AV_H_BPORCH + `AV_H_ACTIVE) &&
                       (y_pos >= `AV_V_BPORCH) &&
                       (y_pos < `AV_V_BPORCH + `AV_V_ACTIVE);

    // bands use raw counter values, not window-relative ones
    assign in_red = (x_pos < `AV_RED_COLUMN_END) || (y_pos > `AV_RED_LINE_START);

    ////////////////////
    // colour select
    ////////////////////

    always_comb begin
        if (!in_window) begin
            rgb_next = BLACK;
        end else if (in_red) begin
            rgb_next = RED;
        end else begin
            rgb_next = GREY;
        end
    end

    // one clock behind the counters, in step with hs/vs
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            de  <= 1'b0;
            rgb <= BLACK;
        end else begin
            de  <= in_window;
            rgb <= rgb_next;
        end
    end

    // blanking carries no colour
    a_black_blank: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        !de |-> (rgb == BLACK));

endmodule

/* hdl/i2s_clock_gen.sv */
/*
 * i2s clock generator
 * bit clock from the master clock, bit strobe,
 * word select and frame start strobe
 */
`include "av_settings.svh"

module i2s_clock_gen (
    input  logic audgen_mclk,
    input  logic reset_n,
    output logic sclk,
    output logic bit_tick,
    output logic lrck,
    output logic frame_start
);
    import audio_pkg::*;

    localparam logic [1:0] DIV_LAST  = 2'(`AV_MCLK_PER_BIT - 1);
    localparam slot_bit_t  SLOT_LAST = slot_bit_t'(`AV_SLOT_BITS - 1);

    logic [1:0] mclk_div;
    slot_bit_t  slot_bit;
    logic       slot_end;

    ////////////////////
    // bit clock
    ////////////////////

    // low for the first half of the divide, high for the second
    assign sclk = mclk_div[1];

    // last mclk of the bit period
    // registers using it update as sclk falls
    assign bit_tick = (mclk_div == DIV_LAST);

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            mclk_div <= '0;
        end else if (bit_tick) begin
            mclk_div <= '0;
        end else begin
            mclk_div <= mclk_div + 1'b1;
        end
    end

    ////////////////////
    // word select
    ////////////////////

    assign slot_end = (slot_bit == SLOT_LAST);

    // right slot ending, left slot of the next frame begins
    assign frame_start = bit_tick && slot_end && lrck;

    // slot counter wraps by itself at 32
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            slot_bit <= '0;
            lrck     <= 1'b0;
        end else if (bit_tick) begin
            slot_bit <= slot_bit + 1'b1;
            if (slot_end) begin
                lrck <= ~lrck;
            end
        end
    end

    // ws must only move with the falling bit clock
    a_lrck_on_tick: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        !$past(bit_tick) |-> $stable(lrck));

endmodule

/* hdl/i2s_serializer.sv */
/*
 * i2s serializer
 * one-pair sample buffer filled over a four-phase req/ack handshake,
 * 64-bit frame shift register and sticky underrun flag
 */
`include "av_settings.svh"

module i2s_serializer (
    input  logic                     audgen_mclk,
    input  logic                     reset_n,
    input  logic                     bit_tick,
    input  logic                     lrck,
    input  logic                     frame_start,
    input  logic                     sample_ack,
    input  audio_pkg::audio_sample_t sample_left,
    input  audio_pkg::audio_sample_t sample_right,
    output logic                     dac,
    output logic                     sample_req,
    output logic                     audio_underrun
);
    import audio_pkg::*;

    localparam int FRAME_BITS = 2 * `AV_SLOT_BITS;
    // zero bits after each sample, one less for the i2s delay bit
    localparam int PAD_BITS   = `AV_SLOT_BITS - `AV_SAMPLE_BITS - 1;

    handshake_state_t        hs_state;
    logic                    buf_full;
    audio_sample_t           buf_left;
    audio_sample_t           buf_right;
    logic                    take_pair;
    logic [FRAME_BITS-1:0]   frame_word;
    logic [FRAME_BITS-1:0]   frame_sr;

    ////////////////////
    // sample handshake
    ////////////////////

    assign sample_req = (hs_state == REQUEST);
    assign take_pair  = (hs_state == REQUEST) && sample_ack;

    // four-phase
    // req only returns once ack has been seen low
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            hs_state <= IDLE;
        end else begin
            case (hs_state)
                IDLE: begin
                    if (!buf_full && !sample_ack) begin
                        hs_state <= REQUEST;
                    end
                end
                REQUEST: begin
                    // pair latched this cycle, req drops next
                    if (sample_ack) begin
                        hs_state <= RELEASE;
                    end
                end
                RELEASE: begin
                    if (!sample_ack) begin
                        hs_state <= IDLE;
                    end
                end
                default: begin
                    hs_state <= IDLE;
                end
            endcase
        end
    end

    // pair buffer
    always_ff @(posedge audgen_mclk) begin
        if (take_pair) begin
            buf_left  <= sample_left;
            buf_right <= sample_right;
        end
    end

    ////////////////////
    // frame shifter
    ////////////////////

    // msb first, one bit late behind each ws edge
    // left slot goes out while lrck is low
    always_comb begin
        if (buf_full) begin
            frame_word = {1'b0, buf_left, {PAD_BITS{1'b0}},
                          1'b0, buf_right, {PAD_BITS{1'b0}}};
        end else begin
            frame_word = '0;
        end
    end

    assign dac = frame_sr[FRAME_BITS-1];

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            frame_sr       <= '0;
            buf_full       <= 1'b0;
            audio_underrun <= 1'b0;
        end else begin
            if (frame_start) begin
                frame_sr <= frame_word;
                buf_full <= 1'b0;
                // no pair ready, frame goes out silent
                if (!buf_full) begin
                    audio_underrun <= 1'b1;
                end
            end else if (bit_tick) begin
                frame_sr <= {frame_sr[FRAME_BITS-2:0], 1'b0};
            end
            // a pair taken on a frame start is kept for the next frame
            if (take_pair) begin
                buf_full <= 1'b1;
            end
        end
    end

    // req must not come back before the source has released ack
    a_req_after_release: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        $rose(sample_req) |-> !$past(sample_ack));

    // delay bit right after each ws edge carries no data
    a_delay_bit_zero: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        $changed(lrck) |-> !dac);

endmodule

/* hdl/av_top.sv */
/*
 * audio/video pattern core
 * raster timing, test pattern and i2s output
 * all on the 12.288 MHz master clock
 */
module av_top (
    input  logic                     audgen_mclk,
    input  logic                     reset_n,
    input  logic                     sample_ack,
    input  audio_pkg::audio_sample_t sample_left,
    input  audio_pkg::audio_sample_t sample_right,
    output logic                     video_hs,
    output logic                     video_vs,
    output logic                     video_de,
    output video_pkg::pixel_rgb_t    video_rgb,
    output logic                     audio_sclk,
    output logic                     audio_lrck,
    output logic                     audio_dac,
    output logic                     sample_req,
    output logic                     audio_underrun
);
    import video_pkg::*;

    raster_pos_t x_pos;
    raster_pos_t y_pos;
    logic        bit_tick;
    logic        frame_start;

    ////////////////////
    // video
    ////////////////////

    video_timing timing_i (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .x_pos       (x_pos),
        .y_pos       (y_pos),
        .hs          (video_hs),
        .vs          (video_vs)
    );

    test_pattern pattern_i (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .x_pos       (x_pos),
        .y_pos       (y_pos),
        .de          (video_de),
        .rgb         (video_rgb)
    );

    ////////////////////
    // audio
    ////////////////////

    i2s_clock_gen clock_gen_i (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .sclk        (audio_sclk),
        .bit_tick    (bit_tick),
        .lrck        (audio_lrck),
        .frame_start (frame_start)
    );

    i2s_serializer serializer_i (
        .audgen_mclk    (audgen_mclk),
        .reset_n        (reset_n),
        .bit_tick       (bit_tick),
        .lrck           (audio_lrck),
        .frame_start    (frame_start),
        .sample_ack     (sample_ack),
        .sample_left    (sample_left),
        .sample_right   (sample_right),
        .dac            (audio_dac),
        .sample_req     (sample_req),
        .audio_underrun (audio_underrun)
    );

endmodule

/* verif/av_top_tb.sv */
/*
 * testbench for the audio/video pattern core
 * random sample source with req/ack delays, video and i2s reference models,
 * per-cycle comparison against the DUT outputs
 */
`include "av_settings.svh"

module av_top_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import video_pkg::*;
    import audio_pkg::*;

    localparam int RESET_CYCLES   = 5;
    localparam int FRAME_CYCLES   = 2 * `AV_SLOT_BITS * `AV_MCLK_PER_BIT;
    localparam int VIDEO_FRAME    = `AV_H_TOTAL * `AV_V_TOTAL;
    // two full video frames, ends just after the third vs
    localparam int RUN_CYCLES     = 2 * VIDEO_FRAME + 2;
    // run length plus roughly ten percent
    localparam int TIMEOUT_CYCLES = 450000;
    // audio frame whose request the source leaves hanging
    localparam int UNDERRUN_FRAME = 6;

    logic          audgen_mclk;
    logic          reset_n;
    logic          sample_ack;
    audio_sample_t sample_left;
    audio_sample_t sample_right;
    logic          video_hs;
    logic          video_vs;
    logic          video_de;
    pixel_rgb_t    video_rgb;
    logic          audio_sclk;
    logic          audio_lrck;
    logic          audio_dac;
    logic          sample_req;
    logic          audio_underrun;

    // cycle count since reset release, stable between rising edges
    int            cyc = 0;
    int            elapsed_cycles = 0;
    logic [31:0]   lfsr_state = 32'hc438;
    // handshake inputs as the DUT saw them at the last rising edge
    logic          edge_ack = 1'b0;
    logic [31:0]   edge_pair = '0;

    // reference model state
    logic          req_m;
    logic          released;
    logic          buf_v;
    logic [31:0]   buf_pair;
    logic [31:0]   frame_pair;
    logic          underrun_m;
    logic          prev_lrck;
    logic          prev_sclk;
    logic          seen_vs;
    int            px;
    int            py;
    int            de_count;
    int            vs_count;

    av_top dut_i (
        .audgen_mclk    (audgen_mclk),
        .reset_n        (reset_n),
        .sample_ack     (sample_ack),
        .sample_left    (sample_left),
        .sample_right   (sample_right),
        .video_hs       (video_hs),
        .video_vs       (video_vs),
        .video_de       (video_de),
        .video_rgb      (video_rgb),
        .audio_sclk     (audio_sclk),
        .audio_lrck     (audio_lrck),
        .audio_dac      (audio_dac),
        .sample_req     (sample_req),
        .audio_underrun (audio_underrun)
    );

    // 20 ns period
    always #10 audgen_mclk = ~audgen_mclk;

    ////////////////////
    // helpers
    ////////////////////

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            report_failure($sformatf("FAIL %s got 0x%h expected 0x%h at cycle %0d",
                                     name, got, expected, cyc));
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] take_random_bits(input int count);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // {de, rgb} for a raw counter position
    function automatic logic [24:0] pattern_ref(input int x, input int y);
        logic win;
        logic red;
        win = (x >= `AV_H_BPORCH) && (x < `AV_H_BPORCH + `AV_H_ACTIVE) &&
              (y >= `AV_V_BPORCH) && (y < `AV_V_BPORCH + `AV_V_ACTIVE);
        red = (x < `AV_RED_COLUMN_END) || (y > `AV_RED_LINE_START);
        if (!win) begin
            return {1'b0, 24'h000000};
        end else if (red) begin
            return {1'b1, 24'hff0000};
        end
        return {1'b1, {3{8'(`AV_GREY_LEVEL)}}};
    endfunction

    // i2s bit for index b of a 64-bit frame, left sample in pair[31:16]
    function automatic logic dac_ref(input logic [31:0] pair, input int b);
        logic [15:0] sample;
        int          pos;
        pos    = b % `AV_SLOT_BITS;
        sample = (b < `AV_SLOT_BITS) ? pair[31:16] : pair[15:0];
        // one delay bit after the ws edge, then msb first, then zero padding
        if (pos >= 1 && pos <= `AV_SAMPLE_BITS) begin
            return sample[`AV_SAMPLE_BITS - pos];
        end
        return 1'b0;
    endfunction

    ////////////////////
    // per-cycle checks
    ////////////////////

    task automatic check_video_cycle();
        logic [24:0] exp;
        if (seen_vs) begin
            px++;
            if (px == `AV_H_TOTAL) begin
                px = 0;
                py = (py + 1) % `AV_V_TOTAL;
            end
            compare_value("video_vs", video_vs, (px == 0) && (py == 0));
        end else begin
            // first vs one cycle after release
            compare_value("video_vs", video_vs, cyc == 1);
        end
        if (video_vs) begin
            if (seen_vs) begin
                compare_value("active pixel count", de_count, `AV_H_ACTIVE * `AV_V_ACTIVE);
            end
            seen_vs  = 1'b1;
            px       = 0;
            py       = 0;
            de_count = 0;
            vs_count++;
        end
        compare_value("video_hs", video_hs, px == `AV_HS_COLUMN);
        exp = pattern_ref(px, py);
        compare_value("video_de", video_de, exp[24]);
        compare_value("video_rgb", video_rgb, exp[23:0]);
        if (video_de) begin
            de_count++;
        end
    endtask

    task automatic check_audio_cycle();
        logic frame;
        logic take;
        logic req_new;
        logic exp_dac;
        frame   = (cyc % FRAME_CYCLES) == 0;
        take    = req_m && edge_ack;
        // req drops after ack, returns only with an empty buffer and ack seen low
        req_new = req_m ? !edge_ack : (!buf_v && !edge_ack && released);
        released = take ? 1'b0 : (released || !edge_ack);
        if (frame) begin
            if (buf_v) begin
                frame_pair = buf_pair;
            end else begin
                frame_pair = '0;
                underrun_m = 1'b1;
            end
            buf_v = 1'b0;
        end
        if (take) begin
            buf_pair = edge_pair;
            buf_v    = 1'b1;
        end
        req_m = req_new;
        compare_value("sample_req", sample_req, req_m);
        compare_value("audio_underrun", audio_underrun, underrun_m);
        compare_value("audio_sclk", audio_sclk,
                      (cyc % `AV_MCLK_PER_BIT) >= (`AV_MCLK_PER_BIT / 2));
        compare_value("audio_lrck", audio_lrck,
                      (cyc / (`AV_SLOT_BITS * `AV_MCLK_PER_BIT)) % 2);
        if (audio_lrck !== prev_lrck && !(prev_sclk && !audio_sclk)) begin
            report_failure("audio_lrck changed away from a falling audio_sclk edge");
        end
        // silent until the first frame is loaded
        exp_dac = 1'b0;
        if (cyc >= FRAME_CYCLES) begin
            exp_dac = dac_ref(frame_pair,
                              ((cyc - FRAME_CYCLES) % FRAME_CYCLES) / `AV_MCLK_PER_BIT);
        end
        compare_value("audio_dac", audio_dac, exp_dac);
        prev_lrck = audio_lrck;
        prev_sclk = audio_sclk;
    endtask

    always @(posedge audgen_mclk) begin
        cyc       <= reset_n ? cyc + 1 : 0;
        edge_ack  <= sample_ack;
        edge_pair <= {sample_left, sample_right};
    end

    // comparison on the falling edge, where outputs are settled
    always @(negedge audgen_mclk) begin
        if (cyc == 0) begin
            compare_value("video_hs", video_hs, 0);
            compare_value("video_vs", video_vs, 0);
            compare_value("video_de", video_de, 0);
            compare_value("video_rgb", video_rgb, 0);
            compare_value("audio_sclk", audio_sclk, 0);
            compare_value("audio_lrck", audio_lrck, 0);
            compare_value("audio_dac", audio_dac, 0);
            compare_value("sample_req", sample_req, 0);
            compare_value("audio_underrun", audio_underrun, 0);
            req_m      = 1'b0;
            released   = 1'b1;
            buf_v      = 1'b0;
            underrun_m = 1'b0;
            frame_pair = '0;
            prev_lrck  = 1'b0;
            prev_sclk  = 1'b0;
            seen_vs    = 1'b0;
            px         = 0;
            py         = 0;
            de_count   = 0;
            vs_count   = 0;
        end else begin
            check_video_cycle();
            check_audio_cycle();
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    // slow sample source, random ack delay of 0 to 7 cycles
    initial begin : sample_source
        int   delay;
        logic skipped;
        skipped = 1'b0;
        forever begin
            @(negedge audgen_mclk);
            if (cyc > 0 && sample_req) begin
                if (!skipped && (cyc / FRAME_CYCLES) == UNDERRUN_FRAME) begin
                    skipped = 1'b1;
                    // hold ack low past the next frame start
                    while (cyc < (UNDERRUN_FRAME + 1) * FRAME_CYCLES + 8) begin
                        @(negedge audgen_mclk);
                    end
                end
                delay = int'(take_random_bits(3));
                repeat (delay) @(negedge audgen_mclk);
                sample_left  = audio_sample_t'(take_random_bits(16));
                sample_right = audio_sample_t'(take_random_bits(16));
                sample_ack   = 1'b1;
                do begin
                    @(negedge audgen_mclk);
                end while (sample_req);
                sample_ack = 1'b0;
            end
        end
    end

    initial begin
        audgen_mclk  = 1'b0;
        reset_n      = 1'b0;
        sample_ack   = 1'b0;
        sample_left  = '0;
        sample_right = '0;
        repeat (RESET_CYCLES) @(negedge audgen_mclk);
        reset_n = 1'b1;
        while (cyc < RUN_CYCLES) begin
            @(negedge audgen_mclk);
        end
        // underrun frame was hit and three frame starts were seen
        compare_value("audio_underrun", audio_underrun, 1);
        compare_value("vs pulse count", vs_count, 3);
        $display("** PASS **");
        $finish;
    end

    // hang guard
    always @(posedge audgen_mclk) begin
        elapsed_cycles = elapsed_cycles + 1;
        if (elapsed_cycles >= TIMEOUT_CYCLES) begin
            report_failure("error: the run did not finish within the cycle limit");
        end
    end

endmodule

/* project.f */
+incdir+hdl
hdl/video_pkg.sv
hdl/audio_pkg.sv
hdl/video_timing.sv
hdl/test_pattern.sv
hdl/i2s_clock_gen.sv
hdl/i2s_serializer.sv
hdl/av_top.sv
verif/av_top_tb.sv

/* Bender.yml */
package:
  name: av_pattern

export_include_dirs:
  - hdl

sources:
  - hdl/video_pkg.sv
  - hdl/audio_pkg.sv
  - hdl/video_timing.sv
  - hdl/test_pattern.sv
  - hdl/i2s_clock_gen.sv
  - hdl/i2s_serializer.sv
  - hdl/av_top.sv
  - target: test
    files:
      - verif/av_top_tb.sv
